// File: source/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int XLEN         = 32;
    localparam int ADDR_W       = 14;
    localparam int INT_W        = 13;
    localparam int SW_INT_W     = 2;
    localparam int HW_INT_W     = 9;
    localparam int TI_BIT       = 11;
    localparam int EENTRY_ALIGN = 6;
    localparam int TVAL_SHIFT   = 2;
    localparam int TICLR_CLR_BIT = 0;

    // estat field positions
    localparam int ECODE_LSB    = 16;
    localparam int ESUBCODE_LSB = 22;

    localparam logic [XLEN-1:0] TVAL_EXPIRED = '1;

    typedef enum logic [ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECTL   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    typedef enum logic [1:0] {
        TRAP_NONE = 2'd0,
        TRAP_EXCP = 2'd1,
        TRAP_ERTN = 2'd2
    } trap_kind_e;

    typedef struct packed {
        logic            valid;
        csr_addr_e       addr;
        logic [XLEN-1:0] data;
    } csr_write_t;

    typedef struct packed {
        logic crmd;
        logic prmd;
        logic ectl;
        logic estat;
        logic era;
        logic eentry;
        logic save0;
        logic save1;
        logic save2;
        logic save3;
        logic tid;
        logic tcfg;
        logic ticlr;
    } csr_wen_t;

    typedef struct packed {
        trap_kind_e      kind;
        logic [XLEN-1:0] era;
        logic [5:0]      ecode;
        logic [8:0]      esubcode;
    } trap_t;

    typedef struct packed {
        logic [22:0] zero;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] zero;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    // direct address translation after reset
    localparam crmd_t CRMD_RESET = '{
        zero: '0, datm: 2'd0, datf: 2'd0, pg: 1'b0, da: 1'b1, ie: 1'b0, plv: 2'd0
    };

endpackage

`default_nettype wire

// File: source/csr_access.sv
`timescale 1ns/10ps
`default_nettype none

module csr_access (
    input  logic                     clk,
    input  logic                     reset,
    input  csr_pkg::csr_write_t      wr,
    input  csr_pkg::csr_addr_e       rd_addr,
    output csr_pkg::csr_wen_t        wen,
    output logic [csr_pkg::XLEN-1:0] wr_data,
    input  csr_pkg::crmd_t           crmd,
    input  csr_pkg::prmd_t           prmd,
    input  logic [csr_pkg::XLEN-1:0] ectl,
    input  logic [csr_pkg::XLEN-1:0] estat,
    input  logic [csr_pkg::XLEN-1:0] era,
    input  logic [csr_pkg::XLEN-1:0] eentry,
    input  logic [csr_pkg::XLEN-1:0] tid,
    input  logic [csr_pkg::XLEN-1:0] tval,
    input  csr_pkg::tcfg_t           tcfg,
    output logic [csr_pkg::XLEN-1:0] rd_data
);
    import csr_pkg::*;

    logic [XLEN-1:0] save [4];
    logic [3:0]      save_wen;

    // single address decode for the whole csr file
    always_comb begin
        wen = '0;
        if (wr.valid) begin
            case (wr.addr)
                CSR_CRMD:   wen.crmd   = 1'b1;
                CSR_PRMD:   wen.prmd   = 1'b1;
                CSR_ECTL:   wen.ectl   = 1'b1;
                CSR_ESTAT:  wen.estat  = 1'b1;
                CSR_ERA:    wen.era    = 1'b1;
                CSR_EENTRY: wen.eentry = 1'b1;
                CSR_SAVE0:  wen.save0  = 1'b1;
                CSR_SAVE1:  wen.save1  = 1'b1;
                CSR_SAVE2:  wen.save2  = 1'b1;
                CSR_SAVE3:  wen.save3  = 1'b1;
                CSR_TID:    wen.tid    = 1'b1;
                CSR_TCFG:   wen.tcfg   = 1'b1;
                CSR_TICLR:  wen.ticlr  = 1'b1;
                // tval is read only
                default: ;
            endcase
        end
    end

    assign wr_data  = wr.data;
    assign save_wen = {wen.save3, wen.save2, wen.save1, wen.save0};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset) begin
                save[i] <= '0;
            end else if (save_wen[i]) begin
                save[i] <= wr_data;
            end
        end
    end

    always_comb begin
        case (rd_addr)
            CSR_CRMD:   rd_data = crmd;
            CSR_PRMD:   rd_data = prmd;
            CSR_ECTL:   rd_data = ectl;
            CSR_ESTAT:  rd_data = estat;
            CSR_ERA:    rd_data = era;
            CSR_EENTRY: rd_data = eentry;
            CSR_SAVE0:  rd_data = save[0];
            CSR_SAVE1:  rd_data = save[1];
            CSR_SAVE2:  rd_data = save[2];
            CSR_SAVE3:  rd_data = save[3];
            CSR_TID:    rd_data = tid;
            CSR_TCFG:   rd_data = tcfg;
            CSR_TVAL:   rd_data = tval;
            default:    rd_data = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: source/priv_mode_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module priv_mode_ctrl (
    input  logic                     clk,
    input  logic                     reset,
    input  csr_pkg::csr_wen_t        wen,
    input  logic [csr_pkg::XLEN-1:0] wr_data,
    input  csr_pkg::trap_t           trap,
    output csr_pkg::crmd_t           crmd,
    output csr_pkg::prmd_t           prmd,
    output logic [1:0]               plv_out
);
    import csr_pkg::*;

    crmd_t wr_crmd;
    prmd_t wr_prmd;

    assign wr_crmd = crmd_t'(wr_data);
    assign wr_prmd = prmd_t'(wr_data);

    // exception beats ertn, ertn beats a csr write
    always_ff @(posedge clk) begin
        if (reset) begin
            crmd <= CRMD_RESET;
            prmd <= '0;
        end else begin
            case (trap.kind)
                TRAP_EXCP: begin
                    prmd.pplv <= crmd.plv;
                    prmd.pie  <= crmd.ie;
                    crmd.plv  <= 2'd0;
                    crmd.ie   <= 1'b0;
                end
                TRAP_ERTN: begin
                    crmd.plv <= prmd.pplv;
                    crmd.ie  <= prmd.pie;
                end
                default: begin
                    if (wen.crmd) begin
                        crmd.plv  <= wr_crmd.plv;
                        crmd.ie   <= wr_crmd.ie;
                        crmd.da   <= wr_crmd.da;
                        crmd.pg   <= wr_crmd.pg;
                        crmd.datf <= wr_crmd.datf;
                        crmd.datm <= wr_crmd.datm;
                    end
                    if (wen.prmd) begin
                        prmd.pplv <= wr_prmd.pplv;
                        prmd.pie  <= wr_prmd.pie;
                    end
                end
            endcase
        end
    end

    // next privilege level, seen by fetch in the strobe cycle
    always_comb begin
        case (trap.kind)
            TRAP_EXCP: plv_out = 2'd0;
            TRAP_ERTN: plv_out = prmd.pplv;
            default:   plv_out = wen.crmd ? wr_crmd.plv : crmd.plv;
        endcase
    end

endmodule

`default_nettype wire

// File: source/exception_regs.sv
`timescale 1ns/10ps
`default_nettype none

module exception_regs (
    input  logic                         clk,
    input  logic                         reset,
    input  csr_pkg::csr_wen_t            wen,
    input  logic [csr_pkg::XLEN-1:0]     wr_data,
    input  csr_pkg::trap_t               trap,
    input  logic [csr_pkg::HW_INT_W-1:0] interrupt,
    input  logic                         timer_irq,
    input  logic                         ie,
    output logic [csr_pkg::XLEN-1:0]     ectl,
    output logic [csr_pkg::XLEN-1:0]     estat,
    output logic [csr_pkg::XLEN-1:0]     era,
    output logic [csr_pkg::XLEN-1:0]     eentry,
    output logic                         has_int,
    output logic [csr_pkg::XLEN-1:0]     eentry_out,
    output logic [csr_pkg::XLEN-1:0]     era_out
);
    import csr_pkg::*;

    logic [SW_INT_W-1:0]          sw_int;
    logic [HW_INT_W-1:0]          hw_int;
    logic [5:0]                   ecode;
    logic [8:0]                   esubcode;
    logic [XLEN-1:EENTRY_ALIGN]   eentry_base;

    always_ff @(posedge clk) begin
        if (reset) begin
            ectl     <= '0;
            sw_int   <= '0;
            hw_int   <= '0;
            ecode    <= '0;
            esubcode <= '0;
        end else begin
            // hardware lines and ipi, one cycle late
            hw_int <= interrupt;
            if (wen.ectl) begin
                ectl <= XLEN'(wr_data[INT_W-1:0]);
            end
            if (trap.kind == TRAP_EXCP) begin
                ecode    <= trap.ecode;
                esubcode <= trap.esubcode;
            end else if (wen.estat) begin
                sw_int <= wr_data[SW_INT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trap.kind == TRAP_EXCP) begin
            era <= trap.era;
        end else if (wen.era) begin
            era <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (wen.eentry) begin
            eentry_base <= wr_data[XLEN-1:EENTRY_ALIGN];
        end
    end

    assign eentry = {eentry_base, {EENTRY_ALIGN{1'b0}}};

    always_comb begin
        estat                       = '0;
        estat[SW_INT_W-1:0]         = sw_int;
        estat[SW_INT_W +: HW_INT_W] = hw_int;
        // timer flag lives in csr_timer
        estat[TI_BIT]               = timer_irq;
        estat[ECODE_LSB +: 6]       = ecode;
        estat[ESUBCODE_LSB +: 9]    = esubcode;
    end

    assign has_int    = (|(ectl[INT_W-1:0] & estat[INT_W-1:0])) & ie;
    assign eentry_out = eentry;
    assign era_out    = era;

endmodule

`default_nettype wire

// File: source/csr_timer.sv
`timescale 1ns/10ps
`default_nettype none

module csr_timer (
    input  logic                     clk,
    input  logic                     reset,
    input  csr_pkg::csr_wen_t        wen,
    input  logic [csr_pkg::XLEN-1:0] wr_data,
    output logic [csr_pkg::XLEN-1:0] tid,
    output csr_pkg::tcfg_t           tcfg,
    output logic [csr_pkg::XLEN-1:0] tval,
    output logic                     timer_irq
);
    import csr_pkg::*;

    tcfg_t           wr_tcfg;
    logic            timer_en;
    logic            expire;
    logic            clear;
    logic [XLEN-1:0] reload;

    assign wr_tcfg = tcfg_t'(wr_data);
    assign expire  = timer_en && (tval == '0);
    assign clear   = wen.ticlr && wr_data[TICLR_CLR_BIT];
    assign reload  = XLEN'(tcfg.initval) << TVAL_SHIFT;

    always_ff @(posedge clk) begin
        if (reset) begin
            tid       <= '0;
            tcfg      <= '0;
            timer_en  <= 1'b0;
            tval      <= '0;
            timer_irq <= 1'b0;
        end else begin
            if (wen.tid) begin
                tid <= wr_data;
            end

            if (wen.tcfg) begin
                tcfg     <= wr_tcfg;
                timer_en <= wr_tcfg.en;
                tval     <= XLEN'(wr_tcfg.initval) << TVAL_SHIFT;
            end else if (expire) begin
                // one-shot stops here
                timer_en <= tcfg.periodic;
                tval     <= tcfg.periodic ? reload : TVAL_EXPIRED;
            end else if (timer_en) begin
                tval <= tval - 1'b1;
            end

            // clear wins over a new config, which wins over expiry
            if (clear) begin
                timer_irq <= 1'b0;
            end else if (!wen.tcfg && expire) begin
                timer_irq <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit (
    input  logic                         clk,
    input  logic                         reset,
    input  csr_pkg::csr_addr_e           rd_addr,
    input  csr_pkg::csr_write_t          wr,
    input  csr_pkg::trap_t               trap,
    input  logic [csr_pkg::HW_INT_W-1:0] interrupt,
    output logic [csr_pkg::XLEN-1:0]     rd_data,
    output logic                         has_int,
    output logic [1:0]                   plv_out,
    output logic [csr_pkg::XLEN-1:0]     eentry_out,
    output logic [csr_pkg::XLEN-1:0]     era_out
);
    import csr_pkg::*;

    csr_wen_t        wen;
    logic [XLEN-1:0] wr_data;
    crmd_t           crmd;
    prmd_t           prmd;
    logic [XLEN-1:0] ectl;
    logic [XLEN-1:0] estat;
    logic [XLEN-1:0] era;
    logic [XLEN-1:0] eentry;
    logic [XLEN-1:0] tid;
    tcfg_t           tcfg;
    logic [XLEN-1:0] tval;
    logic            timer_irq;

    csr_access u_access (
        .clk     (clk),
        .reset   (reset),
        .wr      (wr),
        .rd_addr (rd_addr),
        .wen     (wen),
        .wr_data (wr_data),
        .crmd    (crmd),
        .prmd    (prmd),
        .ectl    (ectl),
        .estat   (estat),
        .era     (era),
        .eentry  (eentry),
        .tid     (tid),
        .tval    (tval),
        .tcfg    (tcfg),
        .rd_data (rd_data)
    );

    priv_mode_ctrl u_priv (
        .clk     (clk),
        .reset   (reset),
        .wen     (wen),
        .wr_data (wr_data),
        .trap    (trap),
        .crmd    (crmd),
        .prmd    (prmd),
        .plv_out (plv_out)
    );

    exception_regs u_excp (
        .clk        (clk),
        .reset      (reset),
        .wen        (wen),
        .wr_data    (wr_data),
        .trap       (trap),
        .interrupt  (interrupt),
        .timer_irq  (timer_irq),
        .ie         (crmd.ie),
        .ectl       (ectl),
        .estat      (estat),
        .era        (era),
        .eentry     (eentry),
        .has_int    (has_int),
        .eentry_out (eentry_out),
        .era_out    (era_out)
    );

    csr_timer u_timer (
        .clk       (clk),
        .reset     (reset),
        .wen       (wen),
        .wr_data   (wr_data),
        .tid       (tid),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

// File: sim/csr_ref_model.svh
`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH
`default_nettype none

// register state of the model, updated once per clock edge
logic [XLEN-1:0]     m_crmd;
logic [XLEN-1:0]     m_prmd;
logic [XLEN-1:0]     m_ectl;
logic [XLEN-1:0]     m_era;
logic [XLEN-1:0]     m_eentry;
logic [XLEN-1:0]     m_tid;
logic [XLEN-1:0]     m_tcfg;
logic [XLEN-1:0]     m_tval;
logic [XLEN-1:0]     m_save [4];
logic [1:0]          m_sw;
logic [HW_INT_W-1:0] m_hw;
logic [5:0]          m_ecode;
logic [8:0]          m_esub;
logic                m_ten;
logic                m_ti;

function automatic void model_reset();
    m_crmd   = 32'h0000_0008;
    m_prmd   = '0;
    m_ectl   = '0;
    m_era    = '0;
    m_eentry = '0;
    m_tid    = '0;
    m_tcfg   = '0;
    m_tval   = '0;
    for (int i = 0; i < 4; i++) begin
        m_save[i] = '0;
    end
    m_sw    = '0;
    m_hw    = '0;
    m_ecode = '0;
    m_esub  = '0;
    m_ten   = 1'b0;
    m_ti    = 1'b0;
endfunction

function automatic logic wr_hits(csr_write_t w, csr_addr_e a);
    return w.valid && (w.addr == a);
endfunction

function automatic logic [XLEN-1:0] model_estat();
    logic [XLEN-1:0] e;
    e        = '0;
    e[1:0]   = m_sw;
    e[10:2]  = m_hw;
    e[11]    = m_ti;
    e[21:16] = m_ecode;
    e[30:22] = m_esub;
    return e;
endfunction

function automatic logic [XLEN-1:0] model_read(csr_addr_e a);
    case (a)
        CSR_CRMD:   return m_crmd;
        CSR_PRMD:   return m_prmd;
        CSR_ECTL:   return m_ectl;
        CSR_ESTAT:  return model_estat();
        CSR_ERA:    return m_era;
        CSR_EENTRY: return m_eentry;
        CSR_SAVE0:  return m_save[0];
        CSR_SAVE1:  return m_save[1];
        CSR_SAVE2:  return m_save[2];
        CSR_SAVE3:  return m_save[3];
        CSR_TID:    return m_tid;
        CSR_TCFG:   return m_tcfg;
        CSR_TVAL:   return m_tval;
        default:    return '0;
    endcase
endfunction

function automatic logic model_has_int();
    logic [XLEN-1:0] e;
    e = model_estat();
    return (|(m_ectl[12:0] & e[12:0])) & m_crmd[2];
endfunction

function automatic logic [1:0] model_plv(csr_write_t w, trap_t t);
    if (t.kind == TRAP_EXCP) begin
        return 2'd0;
    end
    if (t.kind == TRAP_ERTN) begin
        return m_prmd[1:0];
    end
    return wr_hits(w, CSR_CRMD) ? w.data[1:0] : m_crmd[1:0];
endfunction

function automatic void model_step(csr_write_t w, trap_t t, logic [HW_INT_W-1:0] irq);
    logic [XLEN-1:0] d;
    logic            excp;
    logic            ertn;
    logic            expire;
    logic            tcfg_wr;
    d       = w.data;
    excp    = (t.kind == TRAP_EXCP);
    ertn    = (t.kind == TRAP_ERTN);
    expire  = m_ten && (m_tval == '0);
    tcfg_wr = wr_hits(w, CSR_TCFG);

    // plv and ie move between crmd and prmd
    if (excp) begin
        m_prmd = m_crmd & 32'h7;
        m_crmd = m_crmd & ~32'h7;
    end else if (ertn) begin
        m_crmd = (m_crmd & ~32'h7) | (m_prmd & 32'h7);
    end else begin
        if (wr_hits(w, CSR_CRMD)) m_crmd = d & 32'h1ff;
        if (wr_hits(w, CSR_PRMD)) m_prmd = d & 32'h7;
    end

    m_hw = irq;
    if (wr_hits(w, CSR_ECTL)) m_ectl = d & 32'h1fff;
    if (wr_hits(w, CSR_EENTRY)) m_eentry = d & ~32'h3f;
    if (excp) begin
        m_ecode = t.ecode;
        m_esub  = t.esubcode;
        m_era   = t.era;
    end else begin
        if (wr_hits(w, CSR_ESTAT)) m_sw = d[1:0];
        if (wr_hits(w, CSR_ERA)) m_era = d;
    end

    if (wr_hits(w, CSR_TICLR) && d[0]) begin
        m_ti = 1'b0;
    end else if (!tcfg_wr && expire) begin
        m_ti = 1'b1;
    end
    if (wr_hits(w, CSR_TID)) m_tid = d;
    if (tcfg_wr) begin
        m_tcfg = d;
        m_ten  = d[0];
        m_tval = d & ~32'h3;
    end else if (expire) begin
        m_ten  = m_tcfg[1];
        m_tval = m_tcfg[1] ? (m_tcfg & ~32'h3) : '1;
    end else if (m_ten) begin
        m_tval = m_tval - 32'd1;
    end

    if (wr_hits(w, CSR_SAVE0)) m_save[0] = d;
    if (wr_hits(w, CSR_SAVE1)) m_save[1] = d;
    if (wr_hits(w, CSR_SAVE2)) m_save[2] = d;
    if (wr_hits(w, CSR_SAVE3)) m_save[3] = d;
endfunction

`default_nettype wire
`endif

// File: sim/csr_tb.sv
`timescale 1ns/10ps
`default_nettype none

module csr_tb;
    import csr_pkg::*;

    logic                clk;
    logic                reset;
    csr_addr_e           rd_addr;
    csr_write_t          wr;
    trap_t               trap;
    logic [HW_INT_W-1:0] interrupt;
    logic [XLEN-1:0]     rd_data;
    logic                has_int;
    logic [1:0]          plv_out;
    logic [XLEN-1:0]     eentry_out;
    logic [XLEN-1:0]     era_out;

    integer seed;
    int     errors;
    int     test_base;
    int     tests_ok;
    int     tests_bad;

    csr_addr_e kept [14] = '{CSR_CRMD, CSR_PRMD, CSR_ECTL, CSR_ESTAT, CSR_ERA, CSR_EENTRY,
                             CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_TID, CSR_TCFG,
                             CSR_TVAL, CSR_TICLR};

    `include "csr_ref_model.svh"

    csr_unit dut (
        .clk        (clk),
        .reset      (reset),
        .rd_addr    (rd_addr),
        .wr         (wr),
        .trap       (trap),
        .interrupt  (interrupt),
        .rd_data    (rd_data),
        .has_int    (has_int),
        .plv_out    (plv_out),
        .eentry_out (eentry_out),
        .era_out    (era_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic csr_write_t make_write(logic valid, csr_addr_e a, logic [XLEN-1:0] d);
        csr_write_t w;
        w.valid = valid;
        w.addr  = a;
        w.data  = d;
        return w;
    endfunction

    function automatic csr_write_t idle_write();
        return make_write(1'b0, CSR_CRMD, '0);
    endfunction

    function automatic trap_t make_trap(trap_kind_e k, logic [XLEN-1:0] era,
                                        logic [5:0] ecode, logic [8:0] esub);
        trap_t t;
        t.kind     = k;
        t.era      = era;
        t.ecode    = ecode;
        t.esubcode = esub;
        return t;
    endfunction

    function automatic trap_t no_trap();
        return make_trap(TRAP_NONE, '0, '0, '0);
    endfunction

    task automatic check_word(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_plv(input logic [1:0] got, input logic [1:0] exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s got %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_base) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d mismatches", name, errors - test_base);
        end
    endtask

    // one clock cycle: drive, compare the combinational outputs, advance the model
    task automatic step_cycle(input csr_write_t w, input trap_t t,
                              input logic [HW_INT_W-1:0] irq, input csr_addr_e ra);
        @(posedge clk);
        #2;
        wr        = w;
        trap      = t;
        interrupt = irq;
        rd_addr   = ra;
        #8;
        check_word(rd_data, model_read(ra), $sformatf("rd_data at %s", ra.name()));
        check_bit(has_int, model_has_int(), "has_int");
        check_plv(plv_out, model_plv(w, t), "plv_out");
        model_step(w, t, irq);
    endtask

    task automatic wait_timer_flag(input int limit, output int cycles);
        cycles = 0;
        do begin
            step_cycle(idle_write(), no_trap(), '0, CSR_ESTAT);
            cycles++;
        end while (!rd_data[TI_BIT] && cycles < limit);
        if (!rd_data[TI_BIT]) begin
            $display("the timer interrupt never came within %0d cycles", limit);
            errors++;
        end
    endtask

    task automatic test_reset();
        csr_addr_e zero_regs [4];
        zero_regs = '{CSR_ESTAT, CSR_ECTL, CSR_TCFG, CSR_TID};
        test_base = errors;
        step_cycle(idle_write(), no_trap(), '0, CSR_CRMD);
        check_word(rd_data, CRMD_RESET, "crmd after reset");
        foreach (zero_regs[i]) begin
            step_cycle(idle_write(), no_trap(), '0, zero_regs[i]);
            check_word(rd_data, '0, $sformatf("%s after reset", zero_regs[i].name()));
            check_bit(has_int, 1'b0, "has_int after reset");
            check_plv(plv_out, 2'd0, "plv_out after reset");
        end
        end_test("reset values");
    endtask

    task automatic test_readback();
        csr_addr_e targets [9];
        targets = '{CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, CSR_EENTRY, CSR_ECTL,
                    CSR_PRMD, CSR_CRMD, CSR_ESTAT};
        test_base = errors;
        foreach (targets[i]) begin
            // eentry is undefined until its first write
            step_cycle(make_write(1'b1, targets[i], rand_word()), no_trap(), '0, CSR_SAVE0);
            step_cycle(idle_write(), no_trap(), '0, targets[i]);
        end
        step_cycle(idle_write(), no_trap(), '0, CSR_EENTRY);
        check_word(rd_data & 32'h3f, '0, "eentry low bits");
        check_word(eentry_out, m_eentry, "eentry_out after write");
        end_test("write and read-back");
    endtask

    task automatic test_trap();
        logic [XLEN-1:0] era_v;
        logic [XLEN-1:0] r;
        era_v     = rand_word();
        r         = rand_word();
        test_base = errors;
        // plv 3, ie set, da kept
        step_cycle(make_write(1'b1, CSR_CRMD, 32'h0000_000f), no_trap(), '0, CSR_CRMD);
        step_cycle(idle_write(), make_trap(TRAP_EXCP, era_v, r[5:0], r[14:6]), '0, CSR_CRMD);
        check_plv(plv_out, 2'd0, "plv_out on exception");
        step_cycle(idle_write(), no_trap(), '0, CSR_PRMD);
        check_word(rd_data, 32'h7, "prmd after exception");
        step_cycle(idle_write(), no_trap(), '0, CSR_ERA);
        check_word(rd_data, era_v, "era after exception");
        check_word(era_out, era_v, "era_out after exception");
        step_cycle(idle_write(), no_trap(), '0, CSR_ESTAT);
        check_word({17'd0, rd_data[30:16]}, {17'd0, r[14:0]}, "estat ecode and esubcode");
        step_cycle(idle_write(), make_trap(TRAP_ERTN, '0, '0, '0), '0, CSR_CRMD);
        check_plv(plv_out, 2'd3, "plv_out on ertn");
        step_cycle(idle_write(), no_trap(), '0, CSR_CRMD);
        check_word(rd_data & 32'h7, 32'h7, "crmd plv and ie after ertn");
        end_test("exception entry and return");
    endtask

    task automatic test_interrupts();
        logic [XLEN-1:0]     r;
        logic [HW_INT_W-1:0] prev_irq;
        csr_write_t          w;
        test_base = errors;
        prev_irq  = '0;
        for (int i = 0; i < 40; i++) begin
            r = rand_word();
            case (r[31:30])
                2'd0: w = make_write(1'b1, CSR_ECTL, rand_word());
                2'd1: w = make_write(1'b1, CSR_CRMD, {23'd0, r[28:20]});
                2'd2: w = make_write(1'b1, CSR_ESTAT, rand_word());
                default: w = idle_write();
            endcase
            step_cycle(w, no_trap(), r[HW_INT_W-1:0], CSR_ESTAT);
            // lines show up one cycle after they are driven
            check_word({23'd0, rd_data[10:2]}, {23'd0, prev_irq}, "estat interrupt lines");
            prev_irq = r[HW_INT_W-1:0];
        end
        end_test("interrupt sampling and has_int");
    endtask

    task automatic test_timer();
        tcfg_t cfg;
        int    n;
        int    cycles;
        test_base   = errors;
        n           = 1 + int'(rand_word() % 8);
        cfg         = '0;
        cfg.initval = 30'(n);
        cfg.en      = 1'b1;
        step_cycle(make_write(1'b1, CSR_TCFG, XLEN'(cfg)), no_trap(), '0, CSR_TCFG);
        // expiry 4n+1 cycles after the write, flag readable one cycle later
        wait_timer_flag(4 * n + 20, cycles);
        check_word(XLEN'(cycles), XLEN'(4 * n + 2), "one-shot expiry cycle");
        step_cycle(idle_write(), no_trap(), '0, CSR_TVAL);
        check_word(rd_data, TVAL_EXPIRED, "tval after one-shot expiry");
        step_cycle(make_write(1'b1, CSR_TICLR, 32'h1), no_trap(), '0, CSR_ESTAT);
        step_cycle(idle_write(), no_trap(), '0, CSR_ESTAT);
        check_bit(rd_data[TI_BIT], 1'b0, "timer bit after ticlr");

        cfg.periodic = 1'b1;
        step_cycle(make_write(1'b1, CSR_TCFG, XLEN'(cfg)), no_trap(), '0, CSR_TCFG);
        wait_timer_flag(4 * n + 20, cycles);
        check_word(XLEN'(cycles), XLEN'(4 * n + 2), "periodic first expiry cycle");
        step_cycle(make_write(1'b1, CSR_TICLR, 32'h1), no_trap(), '0, CSR_ESTAT);
        wait_timer_flag(4 * n + 20, cycles);
        // the clearing cycle counts toward the interval
        check_word(XLEN'(cycles + 1), XLEN'(4 * n + 1), "periodic expiry interval");
        end_test("timer");
    endtask

    task automatic test_random();
        logic [XLEN-1:0] r;
        logic [XLEN-1:0] d;
        logic [XLEN-1:0] e;
        logic [XLEN-1:0] q;
        trap_t           t;
        csr_addr_e       a;
        test_base = errors;
        for (int i = 0; i < 2000; i++) begin
            r = rand_word();
            d = rand_word();
            e = rand_word();
            q = rand_word();
            a = kept[r[7:0] % 14];
            // small initval so the timer expires often
            if (a == CSR_TCFG) begin
                d = d & 32'h3f;
            end
            case (r[12:9])
                4'd0: t = make_trap(TRAP_EXCP, e, r[18:13], r[27:19]);
                4'd1: t = make_trap(TRAP_ERTN, '0, '0, '0);
                default: t = no_trap();
            endcase
            step_cycle(make_write(r[8], a, d), t, q[HW_INT_W-1:0], kept[q[31:16] % 14]);
        end
        step_cycle(idle_write(), no_trap(), '0, CSR_ERA);
        check_word(era_out, m_era, "era_out after random mix");
        check_word(eentry_out, m_eentry, "eentry_out after random mix");
        end_test("random mix");
    endtask

    initial begin
        seed      = 32'h763c37c2;
        errors    = 0;
        test_base = 0;
        tests_ok  = 0;
        tests_bad = 0;
        reset     = 1'b1;
        rd_addr   = CSR_CRMD;
        wr        = '0;
        trap      = '0;
        interrupt = '0;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        model_reset();

        test_reset();
        test_readback();
        test_trap();
        test_interrupts();
        test_timer();
        test_random();

        $display("%0d tests ok, %0d tests failing, %0d mismatches in total",
                 tests_ok, tests_bad, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+sim
source/csr_pkg.sv
source/csr_access.sv
source/priv_mode_ctrl.sv
source/exception_regs.sv
source/csr_timer.sv
source/csr_unit.sv
sim/csr_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module csr_tb -o csr_sim
./obj_dir/csr_sim > sim.log
cat sim.log

if grep -q "Verification failed" sim.log; then
    exit 1
fi
grep -q "Verification passed" sim.log
